//--- source/decode_defines.svh
// width, register-count and NOP pattern macros for the decode stage
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// data path and instruction word width
`define WORD_WIDTH 16

// three bits pick one of eight registers
`define REG_SEL_WIDTH 3

// size of the register file
`define REG_COUNT 8

// opcode 00001 in bits 15:11 with every other bit zero
`define NOP_INSTR 16'h0800

`endif

//--- source/decodePkg.sv
// opcode, ALU operation and format enums plus the decoded control bundle
`default_nettype none

package decodePkg;

	// five-bit primary opcodes, bits 15:11 of the instruction
	typedef enum logic [4:0] {
		OP_HALT    = 5'b00000,
		OP_NOP     = 5'b00001,
		OP_J       = 5'b00100,
		OP_JR      = 5'b00101,
		OP_JAL     = 5'b00110,
		OP_JALR    = 5'b00111,
		OP_ADDI    = 5'b01000,
		OP_SUBI    = 5'b01001,
		OP_XORI    = 5'b01010,
		OP_ANDNI   = 5'b01011,
		OP_ROLI    = 5'b10100,
		OP_SLLI    = 5'b10101,
		OP_RORI    = 5'b10110,
		OP_SRLI    = 5'b10111,
		OP_BEQZ    = 5'b01100,
		OP_BNEZ    = 5'b01101,
		OP_BLTZ    = 5'b01110,
		OP_BGEZ    = 5'b01111,
		OP_ST      = 5'b10000,
		OP_LD      = 5'b10001,
		OP_STU     = 5'b10011,
		OP_LBI     = 5'b11000,
		OP_SLBI    = 5'b10010,
		OP_BTR     = 5'b11001,
		// R-format groups with the function in bits 1:0
		OP_ALU_R   = 5'b11011,
		OP_SHIFT_R = 5'b11010,
		OP_SEQ     = 5'b11100,
		OP_SLT     = 5'b11101,
		OP_SLE     = 5'b11110,
		OP_SCO     = 5'b11111
	} opcodeE;

	// ALU operation handed to execute
	// first two groups line up with the R-format function bits
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_XOR   = 4'd2,
		ALU_ANDN  = 4'd3,
		ALU_ROL   = 4'd4,
		ALU_SLL   = 4'd5,
		ALU_ROR   = 4'd6,
		ALU_SRL   = 4'd7,
		ALU_SEQ   = 4'd8,
		ALU_SLT   = 4'd9,
		ALU_SLE   = 4'd10,
		ALU_SCO   = 4'd11,
		ALU_BTR   = 4'd12,
		ALU_PASSB = 4'd13,
		ALU_SLBI  = 4'd14
	} aluOpE;

	// instruction field layouts
	typedef enum logic [1:0] {
		IFMT1 = 2'd0,
		IFMT2 = 2'd1,
		RFMT  = 2'd2,
		JFMT  = 2'd3
	} formatE;

	// eleven decoded control flags plus the 4-bit ALU op
	typedef struct packed {
		logic  halt;
		logic  nop;
		logic  jal;
		logic  jr;
		logic  jump;
		logic  branch;
		logic  memToReg;
		logic  memRead;
		logic  memWrite;
		logic  aluSrc;
		logic  regWrite;
		aluOpE aluOp;
	} ctrlT;

endpackage

`default_nettype wire

//--- source/rfReadIf.sv
// register file read interface with regFile, selector and consumer modports
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

interface rfReadIf;

	// Rs and Rt selectors
	logic [`REG_SEL_WIDTH-1:0] readSel1;
	logic [`REG_SEL_WIDTH-1:0] readSel2;

	// values read out with the bypass already applied
	logic [`WORD_WIDTH-1:0] readData1;
	logic [`WORD_WIDTH-1:0] readData2;

	// storage side
	modport regFile (input readSel1, readSel2, output readData1, readData2);

	// field decoder drives the selectors
	modport selector (output readSel1, readSel2);

	// branch resolver only needs the Rs value
	modport consumer (input readData1);

endinterface

`default_nettype wire

//--- source/controlUnit.sv
// control unit that maps the opcode to flags and an ALU operation and forces NOP on stall
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module controlUnit (
	input  wire [`WORD_WIDTH-1:0] instr,
	input  wire                   stall,
	output decodePkg::ctrlT       ctrl
);

	logic [`WORD_WIDTH-1:0] ctrlInstr;
	decodePkg::opcodeE      opcode;
	logic [1:0]             funct;

	// stall swaps in the NOP pattern before decoding
	assign ctrlInstr = stall ? `NOP_INSTR : instr;
	assign opcode    = decodePkg::opcodeE'(ctrlInstr[15:11]);
	// function field of the R-format groups
	assign funct     = ctrlInstr[1:0];

	always_comb begin
		// all flags low and add by default
		ctrl       = '0;
		ctrl.aluOp = decodePkg::ALU_ADD;
		case (opcode)
			decodePkg::OP_HALT: ctrl.halt = 1'b1;
			decodePkg::OP_NOP:  ctrl.nop  = 1'b1;
			// jumps
			decodePkg::OP_J: ctrl.jump = 1'b1;
			decodePkg::OP_JR: begin
				ctrl.jump = 1'b1;
				ctrl.jr   = 1'b1;
			end
			decodePkg::OP_JAL: begin
				ctrl.jump     = 1'b1;
				ctrl.jal      = 1'b1;
				// link value goes to r7
				ctrl.regWrite = 1'b1;
			end
			decodePkg::OP_JALR: begin
				ctrl.jump     = 1'b1;
				ctrl.jr       = 1'b1;
				ctrl.jal      = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// immediate arithmetic and logic
			decodePkg::OP_ADDI, decodePkg::OP_SUBI, decodePkg::OP_XORI,
			decodePkg::OP_ANDNI: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				// low two opcode bits pick add, sub, xor, andn
				ctrl.aluOp    = decodePkg::aluOpE'({2'b00, ctrlInstr[12:11]});
			end
			// immediate rotates and shifts
			decodePkg::OP_ROLI, decodePkg::OP_SLLI, decodePkg::OP_RORI,
			decodePkg::OP_SRLI: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = decodePkg::aluOpE'({2'b01, ctrlInstr[12:11]});
			end
			// branches only steer the PC
			decodePkg::OP_BEQZ, decodePkg::OP_BNEZ, decodePkg::OP_BLTZ,
			decodePkg::OP_BGEZ: ctrl.branch = 1'b1;
			// memory ops take the address as Rs plus immediate
			decodePkg::OP_ST: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			decodePkg::OP_LD: begin
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			decodePkg::OP_STU: begin
				// store and then write the address back to Rs
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			decodePkg::OP_LBI: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = decodePkg::ALU_PASSB;
			end
			decodePkg::OP_SLBI: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = decodePkg::ALU_SLBI;
			end
			decodePkg::OP_BTR: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = decodePkg::ALU_BTR;
			end
			// register-register groups where the function bits pick the op
			decodePkg::OP_ALU_R: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = decodePkg::aluOpE'({2'b00, funct});
			end
			decodePkg::OP_SHIFT_R: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = decodePkg::aluOpE'({2'b01, funct});
			end
			// set-on-compare and carry-out
			decodePkg::OP_SEQ, decodePkg::OP_SLT, decodePkg::OP_SLE,
			decodePkg::OP_SCO: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = decodePkg::aluOpE'({2'b10, ctrlInstr[12:11]});
			end
			// unknown opcodes decode as nop
			default: ctrl.nop = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- source/fieldDecoder.sv
// field decoder for the format class, register selectors and extended immediate
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module fieldDecoder (
	input  wire [`WORD_WIDTH-1:0]     instr,
	rfReadIf.selector                 rd,
	output logic [`REG_SEL_WIDTH-1:0] writeRegSel,
	output logic [`WORD_WIDTH-1:0]    immed
);

	decodePkg::opcodeE opcode;
	decodePkg::formatE fmt;
	// 5-bit logic and shift immediates are unsigned
	logic              zeroExt5;

	assign opcode = decodePkg::opcodeE'(instr[15:11]);

	// Rs and Rt sit at fixed positions in every format
	assign rd.readSel1 = instr[10:8];
	assign rd.readSel2 = instr[7:5];

	// format from opcode
	always_comb begin
		case (opcode)
			decodePkg::OP_ADDI, decodePkg::OP_SUBI, decodePkg::OP_XORI,
			decodePkg::OP_ANDNI, decodePkg::OP_ROLI, decodePkg::OP_SLLI,
			decodePkg::OP_RORI, decodePkg::OP_SRLI, decodePkg::OP_ST,
			decodePkg::OP_LD, decodePkg::OP_STU: fmt = decodePkg::IFMT1;
			decodePkg::OP_BEQZ, decodePkg::OP_BNEZ, decodePkg::OP_BLTZ,
			decodePkg::OP_BGEZ, decodePkg::OP_LBI, decodePkg::OP_SLBI,
			decodePkg::OP_JR, decodePkg::OP_JALR: fmt = decodePkg::IFMT2;
			decodePkg::OP_BTR, decodePkg::OP_ALU_R, decodePkg::OP_SHIFT_R,
			decodePkg::OP_SEQ, decodePkg::OP_SLT, decodePkg::OP_SLE,
			decodePkg::OP_SCO: fmt = decodePkg::RFMT;
			// J, JAL, halt, nop and anything unknown
			default: fmt = decodePkg::JFMT;
		endcase
	end

	assign zeroExt5 = (opcode == decodePkg::OP_XORI) || (opcode == decodePkg::OP_ANDNI) ||
		(opcode == decodePkg::OP_ROLI) || (opcode == decodePkg::OP_SLLI) ||
		(opcode == decodePkg::OP_RORI) || (opcode == decodePkg::OP_SRLI);

	// destination register
	always_comb begin
		case (opcode)
			// link register
			decodePkg::OP_JAL, decodePkg::OP_JALR: writeRegSel = 3'd7;
			// these write back into Rs
			decodePkg::OP_LBI, decodePkg::OP_SLBI, decodePkg::OP_STU: writeRegSel = instr[10:8];
			default: begin
				case (fmt)
					decodePkg::IFMT1: writeRegSel = instr[7:5];
					decodePkg::RFMT:  writeRegSel = instr[4:2];
					default:          writeRegSel = instr[10:8];
				endcase
			end
		endcase
	end

	// immediate extension per format
	always_comb begin
		case (fmt)
			decodePkg::IFMT1: begin
				immed = zeroExt5 ? {{(`WORD_WIDTH-5){1'b0}}, instr[4:0]}
					: {{(`WORD_WIDTH-5){instr[4]}}, instr[4:0]};
			end
			decodePkg::IFMT2: begin
				// SLBI alone shifts in an unsigned byte
				immed = (opcode == decodePkg::OP_SLBI) ? {{(`WORD_WIDTH-8){1'b0}}, instr[7:0]}
					: {{(`WORD_WIDTH-8){instr[7]}}, instr[7:0]};
			end
			// 11-bit jump displacement
			decodePkg::JFMT: immed = {{(`WORD_WIDTH-11){instr[10]}}, instr[10:0]};
			// no immediate in R format
			default: immed = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/regFileBypass.sv
// eight-word register file with async clear and write-to-read bypass
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module regFileBypass (
	input  wire                      clk,
	input  wire                      rstN,
	input  wire                      wrEn,
	input  wire [`REG_SEL_WIDTH-1:0] wrSel,
	input  wire [`WORD_WIDTH-1:0]    wrData,
	rfReadIf.regFile                 rd
);

	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];
	// same-cycle hit on each read port
	logic                   hit1;
	logic                   hit2;

	// clear on reset and write on the rising edge
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	assign hit1 = wrEn && (wrSel == rd.readSel1);
	assign hit2 = wrEn && (wrSel == rd.readSel2);

	// pending write wins over the stored word
	assign rd.readData1 = hit1 ? wrData : regs[rd.readSel1];
	assign rd.readData2 = hit2 ? wrData : regs[rd.readSel2];

endmodule

`default_nettype wire

//--- source/branchResolver.sv
// branch resolver for conditions, jump targets, next PC and flush
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module branchResolver (
	input  wire decodePkg::ctrlT     ctrl,
	input  wire [`WORD_WIDTH-1:0]    instr,
	input  wire [`WORD_WIDTH-1:0]    pcIncr,
	input  wire [`WORD_WIDTH-1:0]    immed,
	rfReadIf.consumer                rd,
	output logic [`WORD_WIDTH-1:0]   pcNext,
	output logic                     flush
);

	decodePkg::opcodeE      opcode;
	logic [`WORD_WIDTH-1:0] rsVal;
	logic                   condTrue;
	// PC-relative and register-relative targets
	logic [`WORD_WIDTH-1:0] relTarget;
	logic [`WORD_WIDTH-1:0] regTarget;

	assign opcode = decodePkg::opcodeE'(instr[15:11]);
	assign rsVal  = rd.readData1;

	// condition tests on Rs
	always_comb begin
		case (opcode)
			decodePkg::OP_BEQZ: condTrue = (rsVal == '0);
			decodePkg::OP_BNEZ: condTrue = (rsVal != '0);
			// sign bit for the signed tests
			decodePkg::OP_BLTZ: condTrue = rsVal[`WORD_WIDTH-1];
			decodePkg::OP_BGEZ: condTrue = !rsVal[`WORD_WIDTH-1];
			default:            condTrue = 1'b0;
		endcase
	end

	assign relTarget = pcIncr + immed;
	assign regTarget = rsVal + immed;

	// JR and JALR use Rs while J, JAL and taken branches use pcIncr
	always_comb begin
		if (ctrl.jump && ctrl.jr) begin
			pcNext = regTarget;
		end else if (ctrl.jump || (ctrl.branch && condTrue)) begin
			pcNext = relTarget;
		end else begin
			pcNext = pcIncr;
		end
	end

	// fall-through was fetched, so any redirect needs a flush
	assign flush = (ctrl.branch || ctrl.jump) && (pcNext != pcIncr);

endmodule

`default_nettype wire

//--- source/decodeStage.sv
// decode stage top level wiring the control, field, register file and branch blocks
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decodeStage (
	input  wire                       clk,
	input  wire                       rstN,
	input  wire [`WORD_WIDTH-1:0]     instr,
	input  wire [`WORD_WIDTH-1:0]     pcIncr,
	input  wire                       stall,
	// writeback port from the later stages
	input  wire                       wbWriteEn,
	input  wire [`REG_SEL_WIDTH-1:0]  wbWriteSel,
	input  wire [`WORD_WIDTH-1:0]     wbWriteData,
	output logic                      isHalt,
	output logic                      isNop,
	output logic                      isJal,
	output logic                      isJr,
	output logic                      isJump,
	output logic                      isBranch,
	output logic                      isMemToReg,
	output logic                      isMemRead,
	output logic                      isMemWrite,
	output logic                      aluSrc,
	output logic                      isRegWrite,
	output logic [3:0]                aluOp,
	output logic [`WORD_WIDTH-1:0]    immed,
	output logic [`WORD_WIDTH-1:0]    readData1,
	output logic [`WORD_WIDTH-1:0]    readData2,
	output logic [`REG_SEL_WIDTH-1:0] readSel1,
	output logic [`REG_SEL_WIDTH-1:0] readSel2,
	output logic [`REG_SEL_WIDTH-1:0] writeRegSel,
	output logic [`WORD_WIDTH-1:0]    pcNext,
	output logic                      flush
);

	decodePkg::ctrlT ctrl;
	rfReadIf         rdIf ();

	controlUnit u_controlUnit (.instr(instr), .stall(stall), .ctrl(ctrl));

	// selectors and immediate come from instr even under stall
	fieldDecoder u_fieldDecoder (.instr(instr), .rd(rdIf), .writeRegSel(writeRegSel),
		.immed(immed));

	regFileBypass u_regFile (.clk(clk), .rstN(rstN), .wrEn(wbWriteEn), .wrSel(wbWriteSel),
		.wrData(wbWriteData), .rd(rdIf));

	branchResolver u_branchResolver (.ctrl(ctrl), .instr(instr), .pcIncr(pcIncr),
		.immed(immed), .rd(rdIf), .pcNext(pcNext), .flush(flush));

	// control bundle onto flat ports
	assign isHalt     = ctrl.halt;
	assign isNop      = ctrl.nop;
	assign isJal      = ctrl.jal;
	assign isJr       = ctrl.jr;
	assign isJump     = ctrl.jump;
	assign isBranch   = ctrl.branch;
	assign isMemToReg = ctrl.memToReg;
	assign isMemRead  = ctrl.memRead;
	assign isMemWrite = ctrl.memWrite;
	assign aluSrc     = ctrl.aluSrc;
	assign isRegWrite = ctrl.regWrite;
	assign aluOp      = ctrl.aluOp;

	// register file read side
	assign readSel1  = rdIf.readSel1;
	assign readSel2  = rdIf.readSel2;
	assign readData1 = rdIf.readData1;
	assign readData2 = rdIf.readData2;

endmodule

`default_nettype wire

//--- test/decodeStageTb.sv
// testbench with clock, reset, LFSR data, check task, directed decode tests and timeout
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decodeStageTb;

	// tests need about 85 cycles and 400 leaves a wide margin
	localparam int cycleLimit = 400;

	logic                      clk;
	logic                      rstN;
	logic [`WORD_WIDTH-1:0]    instr;
	logic [`WORD_WIDTH-1:0]    pcIncr;
	logic                      stall;
	logic                      wbWriteEn;
	logic [`REG_SEL_WIDTH-1:0] wbWriteSel;
	logic [`WORD_WIDTH-1:0]    wbWriteData;
	logic                      isHalt, isNop, isJal, isJr, isJump, isBranch;
	logic                      isMemToReg, isMemRead, isMemWrite, aluSrc, isRegWrite;
	logic [3:0]                aluOp;
	logic [`WORD_WIDTH-1:0]    immed, readData1, readData2, pcNext;
	logic [`REG_SEL_WIDTH-1:0] readSel1, readSel2, writeRegSel;
	logic                      flush;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] lfsrState = 32'hf07b87f8;

	decodeStage i_dut (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] randomWord();
		logic [15:0] w;
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], lfsrState[0]};
			lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
		end
		return w;
	endfunction

	function automatic logic [15:0] buildInstr(logic [4:0] op, logic [10:0] rest);
		return {op, rest};
	endfunction

	// halt nop jal jr jump branch memToReg memRead memWrite aluSrc regWrite
	function automatic logic [15:0] flagWord();
		return {5'b0, isHalt, isNop, isJal, isJr, isJump, isBranch, isMemToReg, isMemRead,
			isMemWrite, aluSrc, isRegWrite};
	endfunction

	task automatic compareValues(string name, logic [15:0] expected, logic [15:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// inputs change on the falling edge and outputs settle before the rising edge
	task automatic driveInstr(logic [15:0] word, logic [15:0] pc, logic stallIn);
		@(negedge clk);
		instr = word;
		pcIncr = pc;
		stall = stallIn;
		wbWriteEn = 1'b0;
		#10;
	endtask

	// the same-cycle read of the written register must see the new data on both ports
	task automatic writeRegister(logic [2:0] sel, logic [15:0] data);
		@(negedge clk);
		instr = buildInstr(decodePkg::OP_NOP, {sel, sel, 5'b0});
		stall = 1'b0;
		wbWriteEn = 1'b1;
		wbWriteSel = sel;
		wbWriteData = data;
		#10;
		compareValues($sformatf("bypass1 r%0d", sel), data, readData1);
		compareValues($sformatf("bypass2 r%0d", sel), data, readData2);
	endtask

	task automatic checkCtrl(string name, logic [4:0] op, logic [1:0] funct,
		logic [10:0] expFlags, decodePkg::aluOpE expAlu);
		driveInstr(buildInstr(op, {9'h000, funct}), 16'h0040, 1'b0);
		compareValues({name, " flags"}, {5'b0, expFlags}, flagWord());
		compareValues({name, " aluOp"}, {12'b0, expAlu}, {12'b0, aluOp});
	endtask

	task automatic checkFields(string name, logic [15:0] word, logic [2:0] s1, logic [2:0] s2,
		logic [2:0] ws, logic [15:0] imm);
		driveInstr(word, 16'h0040, 1'b0);
		compareValues({name, " readSel1"}, {13'b0, s1}, {13'b0, readSel1});
		compareValues({name, " readSel2"}, {13'b0, s2}, {13'b0, readSel2});
		compareValues({name, " writeRegSel"}, {13'b0, ws}, {13'b0, writeRegSel});
		compareValues({name, " immed"}, imm, immed);
	endtask

	// flush only when the target moves off the fall-through
	task automatic checkTarget(string name, logic [15:0] word, logic [15:0] pc,
		logic [15:0] expPc);
		driveInstr(word, pc, 1'b0);
		compareValues({name, " pcNext"}, expPc, pcNext);
		compareValues({name, " flush"}, {15'b0, expPc != pc}, {15'b0, flush});
	endtask

	task automatic testRegisterFile();
		logic [15:0] vals [8];
		for (int r = 0; r < 8; r++) begin
			driveInstr(buildInstr(decodePkg::OP_NOP, {3'(r), 3'(r), 5'b0}), 16'h0000, 1'b0);
			compareValues($sformatf("reset r%0d", r), 16'h0000, readData1);
		end
		for (int r = 0; r < 8; r++) begin
			vals[3'(r)] = randomWord();
			writeRegister(3'(r), vals[3'(r)]);
		end
		// stored words on both read ports
		for (int r = 0; r < 8; r++) begin
			driveInstr(buildInstr(decodePkg::OP_NOP, {3'(r), 3'(7 - r), 5'b0}), 16'h0000, 1'b0);
			compareValues($sformatf("read1 r%0d", r), vals[3'(r)], readData1);
			compareValues($sformatf("read2 r%0d", 7 - r), vals[3'(7 - r)], readData2);
		end
	endtask

	task automatic testControlDecode();
		checkCtrl("ADDI", decodePkg::OP_ADDI, 2'b00, 11'b00000000011, decodePkg::ALU_ADD);
		checkCtrl("ANDNI", decodePkg::OP_ANDNI, 2'b00, 11'b00000000011, decodePkg::ALU_ANDN);
		checkCtrl("LD", decodePkg::OP_LD, 2'b00, 11'b00000011011, decodePkg::ALU_ADD);
		checkCtrl("ST", decodePkg::OP_ST, 2'b00, 11'b00000000110, decodePkg::ALU_ADD);
		checkCtrl("STU", decodePkg::OP_STU, 2'b00, 11'b00000000111, decodePkg::ALU_ADD);
		// R-format groups where the function bits pick the op
		checkCtrl("ALU-R sub", decodePkg::OP_ALU_R, 2'b01, 11'b00000000001, decodePkg::ALU_SUB);
		checkCtrl("ALU-R andn", decodePkg::OP_ALU_R, 2'b11, 11'b00000000001, decodePkg::ALU_ANDN);
		checkCtrl("SHIFT-R", decodePkg::OP_SHIFT_R, 2'b10, 11'b00000000001, decodePkg::ALU_ROR);
		checkCtrl("SEQ", decodePkg::OP_SEQ, 2'b00, 11'b00000000001, decodePkg::ALU_SEQ);
		checkCtrl("SLT", decodePkg::OP_SLT, 2'b00, 11'b00000000001, decodePkg::ALU_SLT);
		checkCtrl("SLE", decodePkg::OP_SLE, 2'b00, 11'b00000000001, decodePkg::ALU_SLE);
		checkCtrl("SCO", decodePkg::OP_SCO, 2'b00, 11'b00000000001, decodePkg::ALU_SCO);
		checkCtrl("LBI", decodePkg::OP_LBI, 2'b00, 11'b00000000011, decodePkg::ALU_PASSB);
		checkCtrl("SLBI", decodePkg::OP_SLBI, 2'b00, 11'b00000000011, decodePkg::ALU_SLBI);
		checkCtrl("BTR", decodePkg::OP_BTR, 2'b00, 11'b00000000001, decodePkg::ALU_BTR);
		checkCtrl("HALT", decodePkg::OP_HALT, 2'b00, 11'b10000000000, decodePkg::ALU_ADD);
		checkCtrl("NOP", decodePkg::OP_NOP, 2'b00, 11'b01000000000, decodePkg::ALU_ADD);
		// jump and branch flags
		checkCtrl("J", decodePkg::OP_J, 2'b00, 11'b00001000000, decodePkg::ALU_ADD);
		checkCtrl("JR", decodePkg::OP_JR, 2'b00, 11'b00011000000, decodePkg::ALU_ADD);
		checkCtrl("JAL", decodePkg::OP_JAL, 2'b00, 11'b00101000001, decodePkg::ALU_ADD);
		checkCtrl("JALR", decodePkg::OP_JALR, 2'b00, 11'b00111000001, decodePkg::ALU_ADD);
		checkCtrl("BEQZ", decodePkg::OP_BEQZ, 2'b00, 11'b00000100000, decodePkg::ALU_ADD);
		// opcodes 00010 and 00011 are unused
		checkCtrl("unknown 02", 5'b00010, 2'b00, 11'b01000000000, decodePkg::ALU_ADD);
		checkCtrl("unknown 03", 5'b00011, 2'b00, 11'b01000000000, decodePkg::ALU_ADD);
	endtask

	task automatic testFieldExtraction();
		// 5-bit 10011 is -13 signed and 19 unsigned
		checkFields("ADDI", buildInstr(decodePkg::OP_ADDI, {3'd2, 3'd5, 5'b10011}),
			3'd2, 3'd5, 3'd5, 16'hfff3);
		checkFields("XORI", buildInstr(decodePkg::OP_XORI, {3'd2, 3'd5, 5'b10011}),
			3'd2, 3'd5, 3'd5, 16'h0013);
		checkFields("STU", buildInstr(decodePkg::OP_STU, {3'd3, 3'd6, 5'b00100}),
			3'd3, 3'd6, 3'd3, 16'h0004);
		// byte 9c has Rt bits 100
		checkFields("LBI", buildInstr(decodePkg::OP_LBI, {3'd4, 8'h9c}),
			3'd4, 3'd4, 3'd4, 16'hff9c);
		checkFields("SLBI", buildInstr(decodePkg::OP_SLBI, {3'd6, 8'h9c}),
			3'd6, 3'd4, 3'd6, 16'h009c);
		checkFields("ALU-R", buildInstr(decodePkg::OP_ALU_R, {3'd1, 3'd6, 3'd3, 2'b01}),
			3'd1, 3'd6, 3'd3, 16'h0000);
		// displacement 510 puts 5 and 0 in the selector fields, far from r7
		checkFields("JAL", buildInstr(decodePkg::OP_JAL, 11'h510), 3'd5, 3'd0, 3'd7, 16'hfd10);
	endtask

	task automatic testBranches();
		logic [15:0]       rsVals [3] = '{16'h0000, 16'h1234, 16'h8001};
		decodePkg::opcodeE ops [4] = '{decodePkg::OP_BEQZ, decodePkg::OP_BNEZ,
			decodePkg::OP_BLTZ, decodePkg::OP_BGEZ};
		logic              taken;
		for (int s = 0; s < 3; s++) begin
			writeRegister(3'(s + 1), rsVals[2'(s)]);
		end
		for (int o = 0; o < 4; o++) begin
			for (int s = 0; s < 3; s++) begin
				case (ops[2'(o)])
					decodePkg::OP_BEQZ: taken = rsVals[2'(s)] == 16'h0000;
					decodePkg::OP_BNEZ: taken = rsVals[2'(s)] != 16'h0000;
					decodePkg::OP_BLTZ: taken = rsVals[2'(s)][15];
					default:            taken = !rsVals[2'(s)][15];
				endcase
				// displacement -8 from 0x0100
				checkTarget($sformatf("%s r%0d", ops[2'(o)].name(), s + 1),
					buildInstr(ops[2'(o)], {3'(s + 1), 8'hf8}), 16'h0100,
					taken ? 16'h00f8 : 16'h0100);
			end
		end
		checkTarget("BEQZ zero disp", buildInstr(decodePkg::OP_BEQZ, {3'd1, 8'h00}), 16'h0100,
			16'h0100);
	endtask

	// r2 holds 1234 and r3 holds 8001 from the branch test
	task automatic testJumps();
		checkTarget("J", buildInstr(decodePkg::OP_J, 11'h020), 16'h0200, 16'h0220);
		checkTarget("JAL", buildInstr(decodePkg::OP_JAL, 11'h7fc), 16'h0200, 16'h01fc);
		checkTarget("JR", buildInstr(decodePkg::OP_JR, {3'd2, 8'h10}), 16'h0200, 16'h1244);
		checkTarget("JALR", buildInstr(decodePkg::OP_JALR, {3'd3, 8'hff}), 16'h0200, 16'h8000);
		checkTarget("J zero disp", buildInstr(decodePkg::OP_J, 11'h000), 16'h0200, 16'h0200);
	endtask

	task automatic testStall();
		// r1 is zero, so this BEQZ would be taken
		driveInstr(buildInstr(decodePkg::OP_BEQZ, {3'd1, 8'hf8}), 16'h0300, 1'b1);
		compareValues("stall branch flags", {5'b0, 11'b01000000000}, flagWord());
		compareValues("stall branch pcNext", 16'h0300, pcNext);
		compareValues("stall branch flush", 16'h0000, {15'b0, flush});
		driveInstr(buildInstr(decodePkg::OP_ADDI, {3'd2, 3'd5, 5'h01}), 16'h0300, 1'b1);
		compareValues("stall ADDI flags", {5'b0, 11'b01000000000}, flagWord());
		compareValues("stall ADDI readSel1", 16'h0002, {13'b0, readSel1});
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		instr = `NOP_INSTR;
		pcIncr = '0;
		stall = 1'b0;
		wbWriteEn = 1'b0;
		wbWriteSel = '0;
		wbWriteData = '0;
		repeat (5) @(posedge clk);
		// NOP held through reset keeps the control outputs low
		compareValues("reset control", 16'h0000,
			{10'b0, isRegWrite, isMemWrite, isMemRead, isBranch, isJump, flush});
		@(negedge clk);
		rstN = 1'b1;
		testRegisterFile();
		testControlDecode();
		testFieldExtraction();
		testBranches();
		testJumps();
		testStall();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+source
source/decodePkg.sv
source/rfReadIf.sv
source/controlUnit.sv
source/fieldDecoder.sv
source/regFileBypass.sv
source/branchResolver.sv
source/decodeStage.sv
test/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module decodeStageTb --Mdir obj_dir -o simDecode
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simDecode)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
